// File: exec_core.f
+incdir+include
src/exec_core_pkg.sv
src/alu.sv
src/forward_unit.sv
src/pipe_reg.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/exec_core.sv
tests/tb_exec_core.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_exec_core
FILELIST  ?= exec_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(wildcard include/*.svh src/*.sv tests/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

check: run
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/exec_core_tests.txt
# I: instruction pc_plus_two | W: register data | R: next_pc (all hex)
# Expected W and R lines are in program order, squashed slots have none
I c135 0102
W 1 0035
I 91a7 0104
W 1 35a7
I c2f0 0106
W 2 fff0
I d94c 0108
W 3 3597
I db51 010a
W 4 ca59
I dc37 010c
W 5 ca58
I df1a 010e
W 6 0000
I 41dd 0110
W 6 35a4
I 4e45 0112
W 2 ca61
I 517f 0114
W 3 35b8
I 5b8f 0116
W 4 35b0
I c504 0118
W 5 0004
I d1b8 011a
W 6 5a73
I d1be 011c
W 7 735a
I d1ab 011e
W 2 035a
I b18c 0120
W 4 5a73
I ac81 0122
W 4 b4e6
I bccf 0124
W 6 0001
I c91c 0126
W 7 e5ac
I e12c 0128
W 3 0001
I ec2c 012a
W 3 0001
I f18c 012c
W 3 0000
I fc8c 012e
W 3 0001
# Branches and jumps, a taken one drops the next slot
I 6006 0130
R 0136
I c1ff 0132
I 6808 0138
I 740a 013a
R 0144
I 4241 013c
I 7c02 0146
I 3020 0148
W 7 0148
R 0168
I c211 014a
I 2f04 016a
R 014c
I 5161 016c
I 3afe 014e
W 7 014e
R 0358
I c3aa 0150
I 27f0 035a
R 034a
I c4aa 035c
I dff4 034c
W 5 029c
I 0800 034e
I 0000 0350

// File: tests/tb_exec_core.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module tb_exec_core;

  localparam logic [4:0] LBI_OP  = 5'b11000;
  localparam logic [4:0] SLBI_OP = 5'b10010;
  // add r5, r3, r4
  localparam logic [`WORD_W-1:0] ADD_R5_R3_R4 = 16'hdb94;

  logic                  clk;
  logic                  rst_n;
  logic                  instr_valid;
  logic [`WORD_W-1:0]    instr;
  logic [`WORD_W-1:0]    pc_plus_two;
  logic                  redirect;
  logic [`WORD_W-1:0]    next_pc;
  logic                  wb_valid;
  logic                  wb_en;
  logic [`REG_IDX_W-1:0] wb_reg;
  logic [`WORD_W-1:0]    wb_data;

  logic [`WORD_W-1:0]    instr_q [$];
  logic [`WORD_W-1:0]    pc_q [$];
  logic [`REG_IDX_W-1:0] exp_reg_q [$];
  logic [`WORD_W-1:0]    exp_data_q [$];
  logic [`WORD_W-1:0]    exp_pc_q [$];

  int   wb_errors = 0;
  int   redirect_errors = 0;
  int   idle_errors = 0;
  int   other_errors = 0;
  int   wb_seen = 0;
  int   cycles = 0;
  int   limit = 50;
  logic started = 1'b0;

  exec_core dut_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc_plus_two (pc_plus_two),
    .redirect    (redirect),
    .next_pc     (next_pc),
    .wb_valid    (wb_valid),
    .wb_en       (wb_en),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_wb(input logic [`REG_IDX_W-1:0] reg_idx,
                          input logic [`WORD_W-1:0] data);
    logic [`REG_IDX_W-1:0] exp_reg;
    logic [`WORD_W-1:0]    exp_data;
    if (exp_data_q.size() == 0) begin
      wb_errors++;
      $display("Unexpected write-back of %h to r%0d at %0t", data, reg_idx, $time);
      return;
    end
    exp_reg  = exp_reg_q.pop_front();
    exp_data = exp_data_q.pop_front();
    if (reg_idx !== exp_reg || data !== exp_data) begin
      wb_errors++;
      $display("FAILED at %0t: write-back r%0d = %h, expected r%0d = %h",
               $time, reg_idx, data, exp_reg, exp_data);
    end
  endtask

  task automatic check_redirect(input logic [`WORD_W-1:0] target);
    logic [`WORD_W-1:0] exp_pc;
    if (exp_pc_q.size() == 0) begin
      redirect_errors++;
      $display("Unexpected redirect to %h at %0t", target, $time);
      return;
    end
    exp_pc = exp_pc_q.pop_front();
    if (target !== exp_pc) begin
      redirect_errors++;
      $display("FAILED at %0t: next_pc %h, expected %h", $time, target, exp_pc);
    end
  endtask

  task automatic load_tests();
    int                 fd;
    int                 code;
    int                 need;
    string              line;
    logic [`WORD_W-1:0] f1;
    logic [`WORD_W-1:0] f2;
    fd = $fopen("tests/exec_core_tests.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open tests/exec_core_tests.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      code = 0;
      need = 2;
      if (line[0] == "I") begin
        code = $sscanf(line, "I %h %h", f1, f2);
        instr_q.push_back(f1);
        pc_q.push_back(f2);
      end else if (line[0] == "W") begin
        code = $sscanf(line, "W %h %h", f1, f2);
        exp_reg_q.push_back(f1[`REG_IDX_W-1:0]);
        exp_data_q.push_back(f2);
      end else if (line[0] == "R") begin
        need = 1;
        code = $sscanf(line, "R %h", f1);
        exp_pc_q.push_back(f1);
      end
      if (code != need) begin
        other_errors++;
        $display("Malformed line in test file: %s", line);
      end
    end
    $fclose(fd);
  endtask

  // lbi/slbi pairs build a random word in r1..r4, then r3 and r4 are summed
  task automatic add_random_tail();
    logic [31:0]           state;
    logic [7:0]            hi;
    logic [7:0]            lo;
    logic [`REG_IDX_W-1:0] rd;
    logic [`WORD_W-1:0]    pc;
    logic [`WORD_W-1:0]    words [4];
    state = 32'hd0db1837;
    pc    = (pc_q.size() != 0) ? pc_q[pc_q.size()-1] : 16'h0000;
    for (int i = 0; i < 4; i++) begin
      state = lcg_next(state);
      hi    = state[23:16];
      state = lcg_next(state);
      lo    = state[23:16];
      rd    = 3'(i + 1);
      pc    = pc + 16'd2;
      instr_q.push_back({LBI_OP, rd, hi});
      pc_q.push_back(pc);
      exp_reg_q.push_back(rd);
      exp_data_q.push_back({{8{hi[7]}}, hi});
      pc    = pc + 16'd2;
      instr_q.push_back({SLBI_OP, rd, lo});
      pc_q.push_back(pc);
      words[i] = {hi, lo};
      exp_reg_q.push_back(rd);
      exp_data_q.push_back(words[i]);
    end
    pc = pc + 16'd2;
    instr_q.push_back(ADD_R5_R3_R4);
    pc_q.push_back(pc);
    exp_reg_q.push_back(3'd5);
    exp_data_q.push_back(words[2] + words[3]);
  endtask

  always @(negedge clk) begin
    if (rst_n && !started && (wb_valid !== 1'b0 || redirect !== 1'b0)) begin
      idle_errors++;
      $display("Write-back or redirect seen before the first instruction at %0t", $time);
    end else if (rst_n && started) begin
      if (wb_valid) begin
        wb_seen++;
      end
      if (wb_valid && wb_en) begin
        check_wb(wb_reg, wb_data);
      end
      if (redirect) begin
        check_redirect(next_pc);
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n) begin
      cycles <= cycles + 1;
      if (cycles >= limit) begin
        $display("Timeout: run stopped after %0d cycles", cycles);
        $display("TEST FAILED");
        $finish;
      end
    end
  end

  initial begin
    int drain;
    int retire_exp;
    rst_n       <= 1'b0;
    instr_valid <= 1'b0;
    instr       <= '0;
    pc_plus_two <= '0;
    load_tests();
    add_random_tail();
    limit = 4 * instr_q.size() + 50;
    // Each taken branch drops exactly one slot
    retire_exp = instr_q.size() - exp_pc_q.size();

    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    // Quiet window after reset
    repeat (3) @(posedge clk);
    started = 1'b1;

    foreach (instr_q[i]) begin
      instr_valid <= 1'b1;
      instr       <= instr_q[i];
      pc_plus_two <= pc_q[i];
      @(posedge clk);
    end
    instr_valid <= 1'b0;
    instr       <= '0;

    drain = 0;
    while ((exp_data_q.size() != 0 || exp_pc_q.size() != 0) && drain < 8) begin
      @(posedge clk);
      drain++;
    end
    // Let any late extra event show up
    repeat (4) @(posedge clk);

    if (exp_data_q.size() != 0) begin
      other_errors++;
      $display("%0d expected write-backs never appeared", exp_data_q.size());
    end
    if (exp_pc_q.size() != 0) begin
      other_errors++;
      $display("%0d expected redirects never appeared", exp_pc_q.size());
    end
    if (wb_seen != retire_exp) begin
      other_errors++;
      $display("%0d write-back slots seen, %0d expected", wb_seen, retire_exp);
    end

    $display("Errors: write-back %0d, redirect %0d, idle %0d, other %0d",
             wb_errors, redirect_errors, idle_errors, other_errors);
    if (wb_errors + redirect_errors + idle_errors + other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: src/exec_core.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module exec_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic [`WORD_W-1:0]    instr,
  input  logic [`WORD_W-1:0]    pc_plus_two,
  output logic                  redirect,
  output logic [`WORD_W-1:0]    next_pc,
  output logic                  wb_valid,
  output logic                  wb_en,
  output logic [`REG_IDX_W-1:0] wb_reg,
  output logic [`WORD_W-1:0]    wb_data
);
  import exec_core_pkg::*;

  id_ex_t                dec_out;
  id_ex_t                idex_q;
  ex_wb_t                ex_res;
  logic                  dec_valid;
  logic                  idex_valid;
  logic                  ex_valid;
  logic [`WORD_W-1:0]    exmem_data;
  logic                  exmem_write;
  logic [`REG_IDX_W-1:0] exmem_dst;

  // Slot behind a taken branch is dropped at decode
  decode_stage decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .pc_plus_two (pc_plus_two),
    .squash      (redirect),
    .wr_en       (wb_en),
    .wr_reg      (wb_reg),
    .wr_data     (wb_data),
    .id_out      (dec_out),
    .id_valid    (dec_valid)
  );

  pipe_reg #(.payload_t(id_ex_t)) idex_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (1'b0),
    .in_valid  (dec_valid),
    .in_data   (dec_out),
    .out_valid (idex_valid),
    .out_data  (idex_q)
  );

  execute_stage execute_i (
    .id_in       (idex_q),
    .id_valid    (idex_valid),
    .exmem_data  (exmem_data),
    .exmem_write (exmem_write),
    .exmem_dst   (exmem_dst),
    .memwb_data  (wb_data),
    .memwb_write (wb_en),
    .memwb_dst   (wb_reg),
    .ex_out      (ex_res),
    .ex_valid    (ex_valid),
    .redirect    (redirect),
    .next_pc     (next_pc)
  );

  result_stage result_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_in       (ex_res),
    .ex_valid    (ex_valid),
    .exmem_data  (exmem_data),
    .exmem_write (exmem_write),
    .exmem_dst   (exmem_dst),
    .wb_valid    (wb_valid),
    .wb_en       (wb_en),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data)
  );

endmodule

// File: src/result_stage.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module result_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  exec_core_pkg::ex_wb_t ex_in,
  input  logic                  ex_valid,
  output logic [`WORD_W-1:0]    exmem_data,
  output logic                  exmem_write,
  output logic [`REG_IDX_W-1:0] exmem_dst,
  output logic                  wb_valid,
  output logic                  wb_en,
  output logic [`REG_IDX_W-1:0] wb_reg,
  output logic [`WORD_W-1:0]    wb_data
);
  import exec_core_pkg::*;

  ex_wb_t exmem_q;
  ex_wb_t memwb_q;
  logic   exmem_valid;

  pipe_reg #(.payload_t(ex_wb_t)) exmem_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (1'b0),
    .in_valid  (ex_valid),
    .in_data   (ex_in),
    .out_valid (exmem_valid),
    .out_data  (exmem_q)
  );

  pipe_reg #(.payload_t(ex_wb_t)) memwb_reg_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (1'b0),
    .in_valid  (exmem_valid),
    .in_data   (exmem_q),
    .out_valid (wb_valid),
    .out_data  (memwb_q)
  );

  assign exmem_data  = exmem_q.data;
  assign exmem_write = exmem_valid & exmem_q.reg_write;
  assign exmem_dst   = exmem_q.dst;

  assign wb_en   = wb_valid & memwb_q.reg_write;
  assign wb_reg  = memwb_q.dst;
  assign wb_data = memwb_q.data;

  // A retiring entry carries known control, and known data when it writes
  assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> !$isunknown(memwb_q.reg_write) &&
                 (!memwb_q.reg_write || !$isunknown({wb_reg, wb_data})))
    else $error("result: write-back with unknown control or data");

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module execute_stage (
  input  exec_core_pkg::id_ex_t id_in,
  input  logic                  id_valid,
  input  logic [`WORD_W-1:0]    exmem_data,
  input  logic                  exmem_write,
  input  logic [`REG_IDX_W-1:0] exmem_dst,
  input  logic [`WORD_W-1:0]    memwb_data,
  input  logic                  memwb_write,
  input  logic [`REG_IDX_W-1:0] memwb_dst,
  output exec_core_pkg::ex_wb_t ex_out,
  output logic                  ex_valid,
  output logic                  redirect,
  output logic [`WORD_W-1:0]    next_pc
);
  import exec_core_pkg::*;

  localparam int SH_W = $clog2(`WORD_W);
  localparam logic [`WORD_W-1:0] FULL_AMT = `WORD_W;

  logic [1:0]         fwd_a;
  logic [1:0]         fwd_b;
  logic [`WORD_W-1:0] rs_val;
  logic [`WORD_W-1:0] rt_val;
  logic [`WORD_W-1:0] op_a;
  logic [`WORD_W-1:0] op_b;
  logic [`WORD_W-1:0] alu_out;
  logic [`WORD_W-1:0] btr_val;
  logic               carry;
  logic               ofl;
  logic               zero;
  logic               less;
  logic               set_bit;
  logic               taken;

  function automatic logic [`WORD_W-1:0] neg_amt(input logic [`WORD_W-1:0] v);
    return FULL_AMT - {{(`WORD_W-SH_W){1'b0}}, v[SH_W-1:0]};
  endfunction

  forward_unit fwd_i (
    .rs_idx      (id_in.rs_idx),
    .rt_idx      (id_in.rt_idx),
    .uses_rs     (id_in.uses_rs),
    .uses_rt     (id_in.uses_rt),
    .exmem_write (exmem_write),
    .exmem_dst   (exmem_dst),
    .memwb_write (memwb_write),
    .memwb_dst   (memwb_dst),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b)
  );

  assign rs_val = (fwd_a == 2'd1) ? exmem_data :
                  (fwd_a == 2'd2) ? memwb_data : id_in.rs_data;
  assign rt_val = (fwd_b == 2'd1) ? exmem_data :
                  (fwd_b == 2'd2) ? memwb_data : id_in.rt_data;

  // Shifted and 16-minus forms are built from the forwarded values
  always_comb begin
    case (id_in.src_a)
      SRC_A_RS:   op_a = rs_val;
      SRC_A_SHL8: op_a = rs_val << 8;
      default:    op_a = '0;
    endcase
    case (id_in.src_b)
      SRC_B_RT:      op_b = rt_val;
      SRC_B_IMM5:    op_b = id_in.imm5;
      SRC_B_IMM8:    op_b = id_in.imm8;
      SRC_B_RT_NEG:  op_b = neg_amt(rt_val);
      SRC_B_IMM_NEG: op_b = neg_amt(id_in.imm5);
      default:       op_b = '0;
    endcase
  end

  alu alu_i (
    .a     (op_a),
    .b     (op_b),
    .op    (id_in.alu_op),
    .inv_a (id_in.inv_a),
    .inv_b (id_in.inv_b),
    .cin   (id_in.cin),
    .out   (alu_out),
    .carry (carry),
    .ofl   (ofl),
    .zero  (zero)
  );

  assign less = alu_out[`WORD_W-1] ^ ofl;

  always_comb begin
    case (id_in.set_cond)
      2'b00:   set_bit = zero;
      2'b01:   set_bit = less;
      2'b10:   set_bit = less | zero;
      default: set_bit = carry;
    endcase
    for (int i = 0; i < `WORD_W; i++) begin
      btr_val[i] = op_a[`WORD_W-1-i];
    end
  end

  always_comb begin
    case (id_in.br_kind)
      BR_NONE: taken = 1'b0;
      BR_BEQZ: taken = (op_a == '0);
      BR_BNEZ: taken = (op_a != '0);
      BR_BLTZ: taken = op_a[`WORD_W-1];
      BR_BGEZ: taken = !op_a[`WORD_W-1];
      default: taken = 1'b1;
    endcase
    case (id_in.br_kind)
      BR_NONE:        next_pc = id_in.pc_plus_two;
      BR_J, BR_JAL:   next_pc = id_in.pc_plus_two + id_in.imm11;
      BR_JR, BR_JALR: next_pc = op_a + id_in.imm8;
      default:        next_pc = id_in.pc_plus_two + id_in.imm8;
    endcase
  end

  assign redirect = id_valid & taken;
  assign ex_valid = id_valid;

  always_comb begin
    ex_out.dst       = id_in.rd_idx;
    ex_out.reg_write = id_in.reg_write;
    case (id_in.res_sel)
      RES_SET:  ex_out.data = {{(`WORD_W-1){1'b0}}, set_bit};
      RES_BTR:  ex_out.data = btr_val;
      RES_LINK: ex_out.data = id_in.pc_plus_two;
      default:  ex_out.data = alu_out;
    endcase
  end

  // A taken branch needs a fully resolved target
  always_comb begin
    assert final (!redirect || !$isunknown(next_pc))
      else $error("execute: redirect without a valid branch target");
  end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module decode_stage (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic [`WORD_W-1:0]    instr,
  input  logic [`WORD_W-1:0]    pc_plus_two,
  input  logic                  squash,
  input  logic                  wr_en,
  input  logic [`REG_IDX_W-1:0] wr_reg,
  input  logic [`WORD_W-1:0]    wr_data,
  output exec_core_pkg::id_ex_t id_out,
  output logic                  id_valid
);
  import exec_core_pkg::*;

  logic [`WORD_W-1:0]    regs [`REG_CNT];
  logic [`REG_IDX_W-1:0] rs_idx;
  logic [`REG_IDX_W-1:0] rt_idx;
  opcode_e               opcode;
  logic                  undef_op;
  logic                  zext_imm5;
  logic                  zext_imm8;

  // func 01 is the subtract, done as B + ~A + 1
  function automatic alu_op_e arith_op(input logic [1:0] func);
    case (func)
      2'b10:   return ALU_XOR;
      2'b11:   return ALU_ANDN;
      default: return ALU_ADD;
    endcase
  endfunction

  // ror runs as rol with a 16-minus amount
  function automatic alu_op_e shift_op(input logic [1:0] func);
    case (func)
      2'b01:   return ALU_SLL;
      2'b11:   return ALU_SRL;
      default: return ALU_ROL;
    endcase
  endfunction

  function automatic br_kind_e cond_kind(input logic [1:0] func);
    case (func)
      2'b00:   return BR_BEQZ;
      2'b01:   return BR_BNEZ;
      2'b10:   return BR_BLTZ;
      default: return BR_BGEZ;
    endcase
  endfunction

  assign rs_idx   = instr[10:8];
  assign rt_idx   = instr[7:5];
  assign id_valid = instr_valid & ~squash;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_CNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_reg] <= wr_data;
    end
  end

  always_comb begin
    opcode    = opcode_e'(instr[15:11]);
    zext_imm5 = (opcode == OP_XORI) || (opcode == OP_ANDNI);
    zext_imm8 = (opcode == OP_SLBI);
    undef_op  = 1'b0;

    id_out = '0;
    // Write-through so a result retiring this cycle is seen
    id_out.rs_data     = (wr_en && wr_reg == rs_idx) ? wr_data : regs[rs_idx];
    id_out.rt_data     = (wr_en && wr_reg == rt_idx) ? wr_data : regs[rt_idx];
    id_out.rs_idx      = rs_idx;
    id_out.rt_idx      = rt_idx;
    id_out.rd_idx      = instr[4:2];
    id_out.imm5        = {{11{instr[4] & ~zext_imm5}}, instr[4:0]};
    id_out.imm8        = {{8{instr[7] & ~zext_imm8}}, instr[7:0]};
    id_out.imm11       = {{5{instr[10]}}, instr[10:0]};
    id_out.pc_plus_two = pc_plus_two;
    id_out.src_a       = SRC_A_RS;
    id_out.src_b       = SRC_B_ZERO;
    id_out.alu_op      = ALU_ADD;
    id_out.res_sel     = RES_ALU;
    id_out.br_kind     = BR_NONE;
    id_out.set_cond    = instr[12:11];

    case (opcode)
      OP_HALT, OP_NOP: begin
        id_out.reg_write = 1'b0;
      end
      OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
        id_out.uses_rs   = 1'b1;
        id_out.src_b     = SRC_B_IMM5;
        id_out.rd_idx    = instr[7:5];
        id_out.reg_write = 1'b1;
        id_out.alu_op    = arith_op(instr[12:11]);
        id_out.inv_a     = (instr[12:11] == 2'b01);
        id_out.cin       = (instr[12:11] == 2'b01);
      end
      OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
        id_out.uses_rs   = 1'b1;
        id_out.src_b     = (instr[12:11] == 2'b10) ? SRC_B_IMM_NEG : SRC_B_IMM5;
        id_out.rd_idx    = instr[7:5];
        id_out.reg_write = 1'b1;
        id_out.alu_op    = shift_op(instr[12:11]);
      end
      OP_ARITH: begin
        id_out.uses_rs   = 1'b1;
        id_out.uses_rt   = 1'b1;
        id_out.src_b     = SRC_B_RT;
        id_out.reg_write = 1'b1;
        id_out.alu_op    = arith_op(instr[1:0]);
        id_out.inv_a     = (instr[1:0] == 2'b01);
        id_out.cin       = (instr[1:0] == 2'b01);
      end
      OP_SHIFT: begin
        id_out.uses_rs   = 1'b1;
        id_out.uses_rt   = 1'b1;
        id_out.src_b     = (instr[1:0] == 2'b10) ? SRC_B_RT_NEG : SRC_B_RT;
        id_out.reg_write = 1'b1;
        id_out.alu_op    = shift_op(instr[1:0]);
      end
      OP_BTR: begin
        id_out.uses_rs   = 1'b1;
        id_out.res_sel   = RES_BTR;
        id_out.reg_write = 1'b1;
      end
      OP_SEQ, OP_SLT, OP_SLE, OP_SCO: begin
        id_out.uses_rs   = 1'b1;
        id_out.uses_rt   = 1'b1;
        id_out.src_b     = SRC_B_RT;
        id_out.res_sel   = RES_SET;
        id_out.reg_write = 1'b1;
        // sco wants the plain carry of rs + rt
        id_out.inv_b     = (opcode != OP_SCO);
        id_out.cin       = (opcode != OP_SCO);
      end
      OP_LBI, OP_SLBI: begin
        id_out.uses_rs   = (opcode == OP_SLBI);
        id_out.src_a     = (opcode == OP_SLBI) ? SRC_A_SHL8 : SRC_A_ZERO;
        id_out.src_b     = SRC_B_IMM8;
        id_out.rd_idx    = rs_idx;
        id_out.reg_write = 1'b1;
      end
      OP_BEQZ, OP_BNEZ, OP_BLTZ, OP_BGEZ: begin
        id_out.uses_rs = 1'b1;
        id_out.br_kind = cond_kind(instr[12:11]);
      end
      OP_J, OP_JAL: begin
        id_out.br_kind   = (opcode == OP_JAL) ? BR_JAL : BR_J;
        id_out.rd_idx    = '1;
        id_out.res_sel   = RES_LINK;
        id_out.reg_write = (opcode == OP_JAL);
      end
      OP_JR, OP_JALR: begin
        id_out.uses_rs   = 1'b1;
        id_out.br_kind   = (opcode == OP_JALR) ? BR_JALR : BR_JR;
        id_out.rd_idx    = '1;
        id_out.res_sel   = RES_LINK;
        id_out.reg_write = (opcode == OP_JALR);
      end
      default: undef_op = 1'b1;
    endcase
  end

  assert property (@(posedge clk) disable iff (!rst_n) instr_valid |-> !undef_op)
    else $error("decode: undefined opcode %b", instr[15:11]);

endmodule

// File: src/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     clear,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // Payload only moves with a valid entry
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

endmodule

// File: src/forward_unit.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module forward_unit (
  input  logic [`REG_IDX_W-1:0] rs_idx,
  input  logic [`REG_IDX_W-1:0] rt_idx,
  input  logic                  uses_rs,
  input  logic                  uses_rt,
  input  logic                  exmem_write,
  input  logic [`REG_IDX_W-1:0] exmem_dst,
  input  logic                  memwb_write,
  input  logic [`REG_IDX_W-1:0] memwb_dst,
  output logic [1:0]            fwd_a,
  output logic [1:0]            fwd_b
);

  // 0 register file, 1 EX/MEM, 2 MEM/WB; the younger result wins
  function automatic logic [1:0] fwd_sel(
    input logic                  used,
    input logic [`REG_IDX_W-1:0] idx,
    input logic                  ex_wr,
    input logic [`REG_IDX_W-1:0] ex_dst,
    input logic                  wb_wr,
    input logic [`REG_IDX_W-1:0] wb_dst
  );
    if (used && ex_wr && ex_dst == idx) begin
      return 2'd1;
    end
    if (used && wb_wr && wb_dst == idx) begin
      return 2'd2;
    end
    return 2'd0;
  endfunction

  assign fwd_a = fwd_sel(uses_rs, rs_idx, exmem_write, exmem_dst, memwb_write, memwb_dst);
  assign fwd_b = fwd_sel(uses_rt, rt_idx, exmem_write, exmem_dst, memwb_write, memwb_dst);

endmodule

// File: src/alu.sv
`timescale 1ns/1ps
`include "exec_core_macros.svh"

module alu (
  input  logic [`WORD_W-1:0]     a,
  input  logic [`WORD_W-1:0]     b,
  input  exec_core_pkg::alu_op_e op,
  input  logic                   inv_a,
  input  logic                   inv_b,
  input  logic                   cin,
  output logic [`WORD_W-1:0]     out,
  output logic                   carry,
  output logic                   ofl,
  output logic                   zero
);
  import exec_core_pkg::*;

  localparam int SH_W = $clog2(`WORD_W);

  logic [`WORD_W-1:0]   a_in;
  logic [`WORD_W-1:0]   b_in;
  logic [`WORD_W:0]     sum;
  logic [SH_W-1:0]      amt;
  logic [2*`WORD_W-1:0] rol_dbl;
  logic [2*`WORD_W-1:0] ror_dbl;

  assign a_in = inv_a ? ~a : a;
  assign b_in = inv_b ? ~b : b;
  assign sum  = {1'b0, a_in} + {1'b0, b_in} + {{`WORD_W{1'b0}}, cin};
  assign amt  = b[SH_W-1:0];

  // Doubled copy carries the wrapped bits of a rotate
  assign rol_dbl = {a, a} << amt;
  assign ror_dbl = {a, a} >> amt;

  always_comb begin
    case (op)
      ALU_ADD:  out = sum[`WORD_W-1:0];
      ALU_XOR:  out = a ^ b;
      ALU_ANDN: out = a & ~b;
      ALU_ROL:  out = rol_dbl[2*`WORD_W-1:`WORD_W];
      ALU_SLL:  out = a << amt;
      ALU_ROR:  out = ror_dbl[`WORD_W-1:0];
      ALU_SRL:  out = a >> amt;
      default:  out = '0;
    endcase
  end

  assign carry = sum[`WORD_W];
  // Signed overflow, taken on the operands after inversion
  assign ofl   = (a_in[`WORD_W-1] == b_in[`WORD_W-1]) &&
                 (sum[`WORD_W-1] != a_in[`WORD_W-1]);
  assign zero  = (out == '0);

endmodule

// File: src/exec_core_pkg.sv
`include "exec_core_macros.svh"

package exec_core_pkg;

  typedef enum logic [4:0] {
    OP_HALT  = 5'b00000,
    OP_NOP   = 5'b00001,
    OP_J     = 5'b00100,
    OP_JR    = 5'b00101,
    OP_JAL   = 5'b00110,
    OP_JALR  = 5'b00111,
    OP_ADDI  = 5'b01000,
    OP_SUBI  = 5'b01001,
    OP_XORI  = 5'b01010,
    OP_ANDNI = 5'b01011,
    OP_BEQZ  = 5'b01100,
    OP_BNEZ  = 5'b01101,
    OP_BLTZ  = 5'b01110,
    OP_BGEZ  = 5'b01111,
    OP_SLBI  = 5'b10010,
    OP_ROLI  = 5'b10100,
    OP_SLLI  = 5'b10101,
    OP_RORI  = 5'b10110,
    OP_SRLI  = 5'b10111,
    OP_LBI   = 5'b11000,
    OP_BTR   = 5'b11001,
    OP_SHIFT = 5'b11010,
    OP_ARITH = 5'b11011,
    OP_SEQ   = 5'b11100,
    OP_SLT   = 5'b11101,
    OP_SLE   = 5'b11110,
    OP_SCO   = 5'b11111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_XOR, ALU_ANDN, ALU_ROL, ALU_SLL, ALU_ROR, ALU_SRL
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_A_RS, SRC_A_SHL8, SRC_A_ZERO
  } src_a_e;

  // NEG variants feed 16 minus the low amount bits, for ror as a rotate left
  typedef enum logic [2:0] {
    SRC_B_RT, SRC_B_IMM5, SRC_B_IMM8, SRC_B_RT_NEG, SRC_B_IMM_NEG, SRC_B_ZERO
  } src_b_e;

  typedef enum logic [1:0] {
    RES_ALU, RES_SET, RES_BTR, RES_LINK
  } res_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQZ, BR_BNEZ, BR_BLTZ, BR_BGEZ, BR_J, BR_JR, BR_JAL, BR_JALR
  } br_kind_e;

  typedef struct packed {
    logic [`WORD_W-1:0]    rs_data;
    logic [`WORD_W-1:0]    rt_data;
    logic [`REG_IDX_W-1:0] rs_idx;
    logic [`REG_IDX_W-1:0] rt_idx;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic                  uses_rs;
    logic                  uses_rt;
    logic [`WORD_W-1:0]    imm5;
    logic [`WORD_W-1:0]    imm8;
    logic [`WORD_W-1:0]    imm11;
    logic [`WORD_W-1:0]    pc_plus_two;
    alu_op_e               alu_op;
    src_a_e                src_a;
    src_b_e                src_b;
    res_sel_e              res_sel;
    br_kind_e              br_kind;
    logic                  inv_a;
    logic                  inv_b;
    logic                  cin;
    logic [1:0]            set_cond;
    logic                  reg_write;
  } id_ex_t;

  typedef struct packed {
    logic [`REG_IDX_W-1:0] dst;
    logic                  reg_write;
    logic [`WORD_W-1:0]    data;
  } ex_wb_t;

endpackage

// File: include/exec_core_macros.svh
`ifndef EXEC_CORE_MACROS_SVH
`define EXEC_CORE_MACROS_SVH

// Data and instruction word
`define WORD_W 16

// Architectural register file
`define REG_CNT 8
`define REG_IDX_W 3

`endif
